/* hdl/mbus_pkg.sv */
package mbus_pkg;

	typedef struct packed
	{
		logic [3:0] prefix;
		logic [3:0] func;
	} addr_t;

	// Address goes out first, so it sits in the upper bits
	typedef struct packed
	{
		addr_t       addr;
		logic [31:0] data;
	} msg_t;

	// Opcode lives in data[31:28] of a control-channel message
	typedef enum logic [3:0]
	{
		op_nop             = 4'h0,
		op_addr_assign     = 4'h1, // New prefix in data[3:0]
		op_addr_invalidate = 4'h2
	} ctrl_op_e;

	typedef enum logic [1:0]
	{
		st_idle,
		st_addr,
		st_data
	} rx_state_e;

	parameter logic [3:0] BROADCAST_PREFIX = 4'h0;
	parameter logic [3:0] CHANNEL_CTRL     = 4'h0;
	parameter logic [3:0] MASTER_PREFIX    = 4'h1;

	// Start bit + 8 address bits + 32 data bits
	parameter int FRAME_BITS = 41;

endpackage

/* hdl/mbus_rx_deframer.sv */
`timescale 1ns/10ps

module mbus_rx_deframer (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  logic           bus_clk,
	input  logic           bus_data,
	output mbus_pkg::msg_t frame,
	output logic           msg_valid
);

	localparam int CNT_W = $clog2(mbus_pkg::FRAME_BITS);

	logic [1:0]                         clk_sync;
	logic [1:0]                         data_sync;
	logic                               clk_prev;
	logic                               rise;
	logic                               bit_in;
	logic [CNT_W-1:0]                   bit_cnt;
	logic [$bits(mbus_pkg::msg_t)-1:0]  shreg;
	mbus_pkg::rx_state_e                state;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			clk_sync  <= '0;
			data_sync <= '0;
			clk_prev  <= 1'b0;
			rise      <= 1'b0;
			bit_in    <= 1'b0;
		end
		else
		begin
			clk_sync  <= {clk_sync[0], bus_clk};
			data_sync <= {data_sync[0], bus_data};
			clk_prev  <= clk_sync[1];
			rise      <= clk_sync[1] & ~clk_prev; // Bus edge, 3 cycles behind the wire
			bit_in    <= data_sync[1];            // Aligned with rise
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state     <= mbus_pkg::st_idle;
			bit_cnt   <= '0;
			msg_valid <= 1'b0;
		end
		else
		begin
			msg_valid <= 1'b0;
			if (rise)
			begin
				case (state)
					mbus_pkg::st_idle:
					begin
						bit_cnt <= '0;
						if (bit_in)
							state <= mbus_pkg::st_addr; // Start bit
					end
					mbus_pkg::st_addr:
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(7))
							state <= mbus_pkg::st_data;
					end
					mbus_pkg::st_data:
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(mbus_pkg::FRAME_BITS - 2))
						begin
							msg_valid <= 1'b1;
							state     <= mbus_pkg::st_idle;
						end
					end
					default:
						state <= mbus_pkg::st_idle;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (rise && state != mbus_pkg::st_idle)
			shreg <= {shreg[$bits(shreg)-2:0], bit_in}; // MSB first
	end

	assign frame = mbus_pkg::msg_t'(shreg);

	a_valid_pulse: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		msg_valid |=> !msg_valid);

endmodule

/* hdl/mbus_addr_rf.sv */
`timescale 1ns/10ps

module mbus_addr_rf (
	input  logic       CLK_EXT,
	input  logic       RESETn_local,
	input  logic [3:0] addr_in,
	input  logic       addr_wr,
	input  logic       addr_clr,
	output logic [3:0] addr_out,
	output logic       addr_valid
);

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			addr_out   <= '0;
			addr_valid <= 1'b0;
		end
		else if (addr_clr)
		begin
			addr_valid <= 1'b0; // Prefix kept but no longer matched
		end
		else if (addr_wr)
		begin
			addr_out   <= addr_in;
			addr_valid <= 1'b1;
		end
	end

endmodule

/* hdl/mbus_rx_filter.sv */
`timescale 1ns/10ps

module mbus_rx_filter (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  logic           master_en,
	input  mbus_pkg::msg_t frame,
	input  logic           msg_valid,
	input  logic [3:0]     addr_out,
	input  logic           addr_valid,
	output logic [3:0]     addr_in,
	output logic           addr_wr,
	output logic           addr_clr,
	output mbus_pkg::msg_t rx_msg,
	output logic           rx_req,
	input  logic           rx_ack,
	output logic           rx_fail
);

	logic                 is_bcast;
	logic                 is_ctrl;
	logic                 own_match;
	logic                 accept;
	logic                 deliver;
	mbus_pkg::ctrl_op_e   op;

	assign is_bcast = (frame.addr.prefix == mbus_pkg::BROADCAST_PREFIX);
	assign is_ctrl  = is_bcast && (frame.addr.func == mbus_pkg::CHANNEL_CTRL);
	assign op       = mbus_pkg::ctrl_op_e'(frame.data[31:28]);

	always_comb
	begin
		if (master_en)
			own_match = (frame.addr.prefix == mbus_pkg::MASTER_PREFIX);
		else
			own_match = addr_valid && (frame.addr.prefix == addr_out);
	end

	assign accept = is_bcast | own_match;

	// Master acknowledges its own control broadcasts internally
	assign deliver = msg_valid && accept && !(master_en && is_ctrl);

	// A member only takes an assignment while it has no prefix
	assign addr_in  = frame.data[3:0];
	assign addr_wr  = msg_valid && is_ctrl && !master_en && !addr_valid &&
		(op == mbus_pkg::op_addr_assign);
	assign addr_clr = msg_valid && is_ctrl && (op == mbus_pkg::op_addr_invalidate);

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx_req  <= 1'b0;
			rx_fail <= 1'b0;
		end
		else
		begin
			rx_fail <= deliver && rx_req; // Buffer full, message dropped
			if (rx_req)
			begin
				if (rx_ack)
					rx_req <= 1'b0;
			end
			else if (deliver)
			begin
				rx_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (deliver && !rx_req)
			rx_msg <= frame;
	end

	a_req_fall: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		$fell(rx_req) |-> $past(rx_ack));

endmodule

/* hdl/mbus_tx_framer.sv */
`timescale 1ns/10ps

module mbus_tx_framer #(
	parameter int CLK_DIV = 4
) (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  mbus_pkg::msg_t tx_msg,
	input  logic           tx_req,
	output logic           tx_ack,
	output logic           tx_succ,
	output logic           clkout,
	output logic           dout
);

	localparam int DIV_W = $clog2(CLK_DIV);
	localparam int CNT_W = $clog2(mbus_pkg::FRAME_BITS);

	logic                             busy;
	logic [DIV_W-1:0]                 div_cnt;
	logic [CNT_W-1:0]                 bit_cnt;
	logic [mbus_pkg::FRAME_BITS-1:0]  shreg;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			busy    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			tx_ack  <= 1'b0;
			tx_succ <= 1'b0;
		end
		else
		begin
			tx_ack  <= 1'b0;
			tx_succ <= 1'b0;
			if (!busy)
			begin
				if (tx_req)
				begin
					tx_ack  <= 1'b1;
					busy    <= 1'b1;
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end
			else if (div_cnt == DIV_W'(CLK_DIV - 1))
			begin
				div_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == CNT_W'(mbus_pkg::FRAME_BITS - 1))
				begin
					busy    <= 1'b0; // Last bit period done
					tx_succ <= 1'b1;
				end
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Start bit in front of the message, shifted at each bit boundary
	always_ff @(posedge CLK_EXT)
	begin
		if (!busy && tx_req)
			shreg <= {1'b1, tx_msg};
		else if (busy && div_cnt == DIV_W'(CLK_DIV - 1))
			shreg <= {shreg[mbus_pkg::FRAME_BITS-2:0], 1'b0};
	end

	// Low in the first half of each bit, so data moves on the falling edge
	assign clkout = busy && (div_cnt >= DIV_W'(CLK_DIV / 2));
	assign dout   = busy && shreg[mbus_pkg::FRAME_BITS-1];

	a_ack_req: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		tx_ack |-> $past(tx_req));

endmodule

/* hdl/mbus_layer.sv */
`timescale 1ns/10ps

module mbus_layer #(
	parameter int CLK_DIV = 4
) (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  logic           master_en,
	input  logic           clkin,
	input  logic           din,
	output logic           clkout,
	output logic           dout,
	input  mbus_pkg::msg_t tx_msg,
	input  logic           tx_req,
	output logic           tx_ack,
	output logic           tx_succ,
	output mbus_pkg::msg_t rx_msg,
	output logic           rx_req,
	input  logic           rx_ack,
	output logic           rx_fail
);

	logic           rx_clk;
	logic           rx_data;
	mbus_pkg::msg_t frame;
	logic           msg_valid;
	logic [3:0]     addr_in;
	logic           addr_wr;
	logic           addr_clr;
	logic [3:0]     addr_out;
	logic           addr_valid;

	// Master hears its own transmission
	assign rx_clk  = master_en ? clkout : clkin;
	assign rx_data = master_en ? dout : din;

	mbus_rx_deframer i_mbus_rx_deframer (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.bus_clk      (rx_clk),
		.bus_data     (rx_data),
		.frame        (frame),
		.msg_valid    (msg_valid)
	);

	mbus_rx_filter i_mbus_rx_filter (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.master_en    (master_en),
		.frame        (frame),
		.msg_valid    (msg_valid),
		.addr_out     (addr_out),
		.addr_valid   (addr_valid),
		.addr_in      (addr_in),
		.addr_wr      (addr_wr),
		.addr_clr     (addr_clr),
		.rx_msg       (rx_msg),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.rx_fail      (rx_fail)
	);

	mbus_addr_rf i_mbus_addr_rf (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.addr_in      (addr_in),
		.addr_wr      (addr_wr),
		.addr_clr     (addr_clr),
		.addr_out     (addr_out),
		.addr_valid   (addr_valid)
	);

	mbus_tx_framer #(
		.CLK_DIV (CLK_DIV)
	) i_mbus_tx_framer (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.clkout       (clkout),
		.dout         (dout)
	);

endmodule

/* tests/mbus_checker.sv */
`timescale 1ns/10ps

module bus_frame_decoder (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  logic           bus_clk,
	input  logic           bus_data,
	output mbus_pkg::msg_t frame,
	output logic           done
);

	logic       clk_prev;
	logic       active;
	logic [5:0] cnt;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			clk_prev <= 1'b0;
			active   <= 1'b0;
			cnt      <= '0;
			done     <= 1'b0;
			frame    <= '0;
		end
		else
		begin
			clk_prev <= bus_clk;
			done     <= 1'b0;
			if (bus_clk && !clk_prev)
			begin
				if (!active)
				begin
					active <= bus_data; // Start bit
					cnt    <= '0;
				end
				else
				begin
					frame <= {frame[$bits(frame)-2:0], bus_data}; // MSB first
					cnt   <= cnt + 1'b1;
					if (cnt == 6'd39)
					begin
						active <= 1'b0;
						done   <= 1'b1;
					end
				end
			end
		end
	end

endmodule

module mbus_checker (
	input  logic           CLK_EXT,
	input  logic           RESETn_local,
	input  logic           master_en,
	input  logic           clkin,
	input  logic           din,
	input  logic           clkout,
	input  logic           dout,
	input  mbus_pkg::msg_t tx_msg,
	input  logic           tx_ack,
	input  logic           tx_succ,
	input  mbus_pkg::msg_t rx_msg,
	input  logic           rx_req,
	input  logic           rx_ack,
	input  logic           rx_fail,
	input  logic           test_end,
	output int             errors
);

	mbus_pkg::msg_t rx_frame;
	mbus_pkg::msg_t tx_frame;
	logic           rx_done;
	logic           tx_done;
	mbus_pkg::msg_t rx_expect[$];
	mbus_pkg::msg_t tx_expect[$];
	mbus_pkg::msg_t held;
	logic           req_prev = 1'b0;
	logic           buf_full = 1'b0;
	logic           pfx_valid = 1'b0;
	logic [3:0]     pfx = 4'h0;
	int             fail_expect = 0;
	int             fail_seen = 0;
	int             succ_due = 0;
	int             err_cnt = 0;

	assign errors = err_cnt;

	bus_frame_decoder i_rx_decoder (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.bus_clk      (clkin),
		.bus_data     (din),
		.frame        (rx_frame),
		.done         (rx_done)
	);

	bus_frame_decoder i_tx_decoder (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.bus_clk      (clkout),
		.bus_data     (dout),
		.frame        (tx_frame),
		.done         (tx_done)
	);

	task automatic report_mismatch(input string name, input logic [39:0] exp,
		input logic [39:0] act);
		$display("MISMATCH at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
		err_cnt++;
	endtask

	task automatic report_error(input string text);
		$display("ERROR at %0t ns: %s", $time, text);
		err_cnt++;
	endtask

	// Acceptance and control rules of a receiving node
	task automatic model_frame(input mbus_pkg::msg_t f);
		logic       bcast;
		logic       ctrl;
		logic       take;
		logic [3:0] op;
		bcast = (f.addr.prefix == mbus_pkg::BROADCAST_PREFIX);
		ctrl  = bcast && (f.addr.func == mbus_pkg::CHANNEL_CTRL);
		op    = f.data[31:28];
		if (master_en)
			take = bcast || (f.addr.prefix == mbus_pkg::MASTER_PREFIX);
		else
			take = bcast || (pfx_valid && f.addr.prefix == pfx);
		if (master_en && ctrl)
			take = 1'b0; // Swallowed by the master
		if (take && buf_full)
			fail_expect++;
		else if (take)
		begin
			rx_expect.push_back(f);
			buf_full = 1'b1;
		end
		if (ctrl && op == mbus_pkg::op_addr_invalidate)
			pfx_valid = 1'b0;
		else if (ctrl && !master_en && !pfx_valid && op == mbus_pkg::op_addr_assign)
		begin
			pfx_valid = 1'b1;
			pfx       = f.data[3:0];
		end
	endtask

	always @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			req_prev  = 1'b0;
			buf_full  = 1'b0;
			pfx_valid = 1'b0;
		end
		else
		begin
			if (rx_done)
				model_frame(rx_frame);
			if (tx_done)
			begin
				if (tx_expect.size() == 0)
					report_error("frame seen on clkout/dout without a tx_ack");
				else
				begin
					if (tx_frame !== tx_expect[0])
						report_mismatch("clkout/dout frame", tx_expect[0], tx_frame);
					void'(tx_expect.pop_front());
				end
				succ_due++;
			end
			if (tx_ack)
			begin
				tx_expect.push_back(tx_msg);
				if (master_en)
					model_frame(tx_msg); // Loopback
			end
			if (tx_succ)
			begin
				if (succ_due == 0)
					report_error("tx_succ pulsed with no finished frame");
				else
					succ_due--;
			end
			if (rx_fail)
				fail_seen++;
			if (rx_req && !req_prev)
			begin
				if (rx_expect.size() == 0)
				begin
					report_error("rx_req rose while no message was expected");
					held = rx_msg;
				end
				else
				begin
					held = rx_expect.pop_front();
					if (rx_msg !== held)
						report_mismatch("rx_msg", held, rx_msg);
				end
			end
			if (rx_req && rx_ack && rx_msg !== held)
				report_mismatch("rx_msg at rx_ack", held, rx_msg);
			if (rx_ack)
				buf_full = 1'b0;
			req_prev = rx_req;
			if (test_end)
			begin
				if (rx_expect.size() != 0)
					report_error("an expected message never raised rx_req");
				if (tx_expect.size() != 0)
					report_error("an acknowledged tx_msg never appeared on clkout/dout");
				if (succ_due != 0)
					report_error("tx_succ did not follow a transmitted frame");
				if (fail_seen != fail_expect)
					report_mismatch("rx_fail count", fail_expect, fail_seen);
				rx_expect.delete();
				tx_expect.delete();
				succ_due    = 0;
				fail_seen   = 0;
				fail_expect = 0;
			end
		end
	end

endmodule

/* tests/tb_mbus_layer.sv */
`timescale 1ns/10ps

module tb_mbus_layer;

	localparam int CLK_DIV  = 4;
	localparam int N_FRAMES = 6 + 16 + 3 + 6 + 8;
	localparam int LIMIT    = N_FRAMES * (mbus_pkg::FRAME_BITS * 8 + 20) * 2;

	logic           CLK_EXT;
	logic           RESETn_local;
	logic           master_en;
	logic           clkin;
	logic           din;
	logic           clkout;
	logic           dout;
	mbus_pkg::msg_t tx_msg;
	logic           tx_req;
	logic           tx_ack;
	logic           tx_succ;
	mbus_pkg::msg_t rx_msg;
	logic           rx_req;
	logic           rx_ack;
	logic           rx_fail;
	logic           test_end;
	logic           auto_ack;
	logic [15:0]    lfsr;
	int             errors;
	int             err_mark;
	int             tests_run;
	int             tests_failed;
	int             cycles;

	mbus_layer #(
		.CLK_DIV (CLK_DIV)
	) i_mbus_layer (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.master_en    (master_en),
		.clkin        (clkin),
		.din          (din),
		.clkout       (clkout),
		.dout         (dout),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.rx_msg       (rx_msg),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.rx_fail      (rx_fail)
	);

	mbus_checker i_mbus_checker (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.master_en    (master_en),
		.clkin        (clkin),
		.din          (din),
		.clkout       (clkout),
		.dout         (dout),
		.tx_msg       (tx_msg),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.rx_msg       (rx_msg),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.rx_fail      (rx_fail),
		.test_end     (test_end),
		.errors       (errors)
	);

	always #4 CLK_EXT = ~CLK_EXT;

	always @(posedge CLK_EXT)
	begin
		cycles++;
		if (cycles == LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// Layer side acknowledge is held off during the overflow test
	always @(posedge CLK_EXT)
	begin
		#1;
		rx_ack = auto_ack && rx_req;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge CLK_EXT);
		#1;
	endtask

	task automatic random_msg(input logic [3:0] p, output mbus_pkg::msg_t m);
		logic [31:0] r;
		random_bits(4, r);
		m.addr.prefix = p;
		m.addr.func   = r[3:0];
		random_bits(32, r);
		m.data        = r;
	endtask

	function automatic mbus_pkg::msg_t ctrl_msg(input mbus_pkg::ctrl_op_e op,
		input logic [3:0] p);
		mbus_pkg::msg_t m;
		m.addr.prefix = mbus_pkg::BROADCAST_PREFIX;
		m.addr.func   = mbus_pkg::CHANNEL_CTRL;
		m.data        = {op, 24'h0, p};
		return m;
	endfunction

	// Member-mode frame on clkin/din with 8 cycles per bus bit
	task automatic drive_frame(input mbus_pkg::msg_t m);
		logic [mbus_pkg::FRAME_BITS-1:0] bits;
		int                              i;
		bits = {1'b1, m};
		for (i = mbus_pkg::FRAME_BITS - 1; i >= 0; i--)
		begin
			clkin = 1'b0;
			din   = bits[i]; // Data moves while the bus clock is low
			tick(4);
			clkin = 1'b1;
			tick(4);
		end
		clkin = 1'b0;
		din   = 1'b0;
		tick(12);
	endtask

	task automatic send_tx(input mbus_pkg::msg_t m);
		tx_msg = m;
		tx_req = 1'b1;
		tick(1);
		while (!tx_ack)
			tick(1);
		tx_req = 1'b0;
		while (!tx_succ)
			tick(1);
		tick(12);
	endtask

	task automatic finish_test(input string name);
		tick(20);
		test_end = 1'b1;
		tick(1);
		test_end = 1'b0;
		tick(1);
		tests_run++;
		if (errors == err_mark)
			$display("Test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic member_unassigned();
		mbus_pkg::msg_t m;
		logic [31:0]    r;
		int             i;
		for (i = 0; i < 6; i++)
		begin
			random_bits(4, r);
			random_msg(r[3:0], m);
			m.addr.func = m.addr.func | 4'h1; // Stays off the control channel
			if (i % 3 == 0)
				m.addr.prefix = mbus_pkg::BROADCAST_PREFIX;
			else if (m.addr.prefix == mbus_pkg::BROADCAST_PREFIX)
				m.addr.prefix = 4'hf;
			drive_frame(m);
		end
		finish_test("member before assignment");
	endtask

	task automatic member_assigned();
		mbus_pkg::msg_t m;
		logic [31:0]    r;
		logic [3:0]     pfx;
		int             i;
		random_bits(4, r);
		pfx = (r[3:0] == 4'h0) ? 4'h9 : r[3:0];
		drive_frame(ctrl_msg(mbus_pkg::op_addr_assign, pfx));
		for (i = 0; i < 10; i++)
		begin
			random_bits(5, r);
			if (r[4])
				random_msg(pfx, m);
			else
				random_msg((r[3:0] == 4'h0) ? 4'h7 : r[3:0], m);
			drive_frame(m);
		end
		drive_frame(ctrl_msg(mbus_pkg::op_addr_invalidate, 4'h0));
		for (i = 0; i < 4; i++)
		begin
			random_msg(pfx, m);
			drive_frame(m);
		end
		finish_test("assignment and invalidation");
	endtask

	task automatic back_pressure();
		mbus_pkg::msg_t m;
		logic [31:0]    r;
		logic [3:0]     pfx;
		random_bits(4, r);
		pfx = (r[3:0] == 4'h0) ? 4'h3 : r[3:0];
		drive_frame(ctrl_msg(mbus_pkg::op_addr_assign, pfx));
		auto_ack = 1'b0;
		random_msg(pfx, m);
		drive_frame(m);
		random_msg(pfx, m);
		drive_frame(m);
		auto_ack = 1'b1;
		finish_test("receive overflow");
	endtask

	task automatic transmit_member();
		mbus_pkg::msg_t m;
		logic [31:0]    r;
		int             i;
		for (i = 0; i < 6; i++)
		begin
			random_bits(4, r);
			random_msg(r[3:0], m);
			send_tx(m);
		end
		finish_test("transmit");
	endtask

	task automatic master_loopback();
		mbus_pkg::msg_t m;
		logic [31:0]    r;
		int             i;
		master_en = 1'b1;
		tick(4);
		for (i = 0; i < 8; i++)
		begin
			case (i % 4)
				0: random_msg(mbus_pkg::MASTER_PREFIX, m);
				1:
				begin
					random_msg(mbus_pkg::BROADCAST_PREFIX, m);
					m.addr.func = m.addr.func | 4'h1;
				end
				2:
				begin
					if (i < 4)
						m = ctrl_msg(mbus_pkg::op_addr_assign, 4'h5);
					else
						m = ctrl_msg(mbus_pkg::op_addr_invalidate, 4'h5);
				end
				default:
				begin
					random_bits(4, r);
					random_msg(r[3:0], m);
				end
			endcase
			send_tx(m);
		end
		finish_test("master loopback");
		master_en = 1'b0;
	endtask

	initial
	begin
		CLK_EXT      = 1'b0;
		RESETn_local = 1'b0;
		master_en    = 1'b0;
		clkin        = 1'b0;
		din          = 1'b0;
		tx_msg       = '0;
		tx_req       = 1'b0;
		rx_ack       = 1'b0;
		test_end     = 1'b0;
		auto_ack     = 1'b1;
		lfsr         = 16'd28;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycles       = 0;
		tick(2);
		RESETn_local = 1'b1;
		tick(2);
		member_unassigned();
		member_assigned();
		back_pressure();
		transmit_member();
		master_loopback();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* mbus_layer.f */
hdl/mbus_pkg.sv
hdl/mbus_rx_deframer.sv
hdl/mbus_addr_rf.sv
hdl/mbus_rx_filter.sv
hdl/mbus_tx_framer.sv
hdl/mbus_layer.sv
tests/mbus_checker.sv
tests/tb_mbus_layer.sv

/* Bender.yml */
package:
  name: mbus_layer

sources:
  - hdl/mbus_pkg.sv
  - hdl/mbus_rx_deframer.sv
  - hdl/mbus_addr_rf.sv
  - hdl/mbus_rx_filter.sv
  - hdl/mbus_tx_framer.sv
  - hdl/mbus_layer.sv
  - target: test
    files:
      - tests/mbus_checker.sv
      - tests/tb_mbus_layer.sv
